/* mem1_stage_macros.svh */
`ifndef MEM1_STAGE_MACROS_SVH
`define MEM1_STAGE_MACROS_SVH

// Exception codes, standard MIPS Cause.ExcCode values
`define EXC_INT    5'd0
`define EXC_TLBMOD 5'd1
`define EXC_TLBL   5'd2
`define EXC_TLBS   5'd3
`define EXC_ADEL   5'd4
`define EXC_ADES   5'd5
`define EXC_OV     5'd12
`define EXC_TRAP   5'd13

// Cache attributes, only 3 means cacheable
`define CATTR_UNCACHED 3'd2
`define CATTR_CACHED   3'd3
`define K0_RESET_ATTR  3'd3

// Access select codes
`define DM_SB  4'b0000
`define DM_SH  4'b0001
`define DM_SW  4'b0010
`define DM_SWL 4'b0011
`define DM_SWR 4'b0100
`define DM_LBU 4'b0101
`define DM_LB  4'b0110
`define DM_LHU 4'b0111
`define DM_LH  4'b1000
`define DM_LWL 4'b1001
`define DM_LWR 4'b1010
`define DM_LW  4'b1011

`endif

/* mem1_pkg.sv */
package mem1_pkg;

    typedef logic [31:0] vaddr_t;
    typedef logic [31:0] paddr_t;
    typedef logic [31:0] word_t;
    typedef logic [19:0] pfn_t;
    typedef logic [2:0]  cattr_t;
    typedef logic [4:0]  exc_code_t;
    typedef logic [3:0]  dm_sel_t;
    typedef logic [3:0]  wstrb_t;
    typedef logic [4:0]  rstrb_t;
    typedef logic [2:0]  acc_size_t;

    // Request entering the stage
    typedef struct packed {
        logic      valid;
        vaddr_t    vaddr;
        word_t     wdata;       // Store data from rt
        dm_sel_t   dm_sel;
        logic      load;
        logic      store;
        logic      reg_write;
        logic      ll;
        logic      sc;
        logic      exc_valid;   // Exception from an earlier stage
        exc_code_t exc_code;
        logic      exc_tlb_refill;
    } mem_req_t;

    typedef struct packed {
        logic   found;
        logic   valid;
        logic   dirty;
        pfn_t   pfn;
        cattr_t cattr;
    } tlb_resp_t;

    typedef struct packed {
        logic      exception;
        exc_code_t exc_code;
        vaddr_t    badvaddr;
        logic      tlb_refill;
        logic      tlb_exc;
        logic      flush;
    } mem_exc_t;

    typedef struct packed {
        paddr_t    paddr;
        logic      uncached;
        logic      dcache_valid;
        logic      uncache_valid;
        logic      store_en;
        wstrb_t    wstrb;
        word_t     wdata;
        rstrb_t    rstrb;
        acc_size_t size;
        logic      sc_result;
    } mem_access_t;

endpackage

/* k0_config_regs.sv */
`timescale 1ns/100ps

`include "mem1_stage_macros.svh"

module k0_config_regs (
    input  logic             clk,
    input  logic             rst,
    input  logic             cfg_we,
    input  mem1_pkg::cattr_t cfg_k0,
    output mem1_pkg::cattr_t k0_attr
);

    // Config.K0, cache attribute of kseg0
    always_ff @(posedge clk) begin
        if (rst) begin
            k0_attr <= `K0_RESET_ATTR;
        end else if (cfg_we) begin
            k0_attr <= cfg_k0;
        end
    end

endmodule

/* addr_xlate.sv */
`timescale 1ns/100ps

`include "mem1_stage_macros.svh"

module addr_xlate (
    input  mem1_pkg::vaddr_t    vaddr,
    input  mem1_pkg::tlb_resp_t tlb,
    input  mem1_pkg::cattr_t    k0_attr,
    output mem1_pkg::paddr_t    paddr,
    output logic                mapped,
    output logic                uncached
);

    logic kseg0;
    logic k0_cached;
    logic tlb_cached;

    // kuseg and kseg2/3 go through the TLB
    assign mapped = ~vaddr[31] | vaddr[30];
    assign kseg0  = (vaddr[31:29] == 3'b100);

    always_comb begin
        if (mapped) begin
            paddr = {tlb.pfn, vaddr[11:0]};
        end else begin
            paddr = {3'b000, vaddr[28:0]};  // kseg0/kseg1 direct
        end
    end

    assign k0_cached  = kseg0 & (k0_attr == `CATTR_CACHED);
    assign tlb_cached = mapped & (tlb.cattr == `CATTR_CACHED);

    // kseg1 is never cached
    assign uncached = ~(k0_cached | tlb_cached);

endmodule

/* mem_exc_gen.sv */
`timescale 1ns/100ps

`include "mem1_stage_macros.svh"

module mem_exc_gen (
    input  mem1_pkg::mem_req_t  req,
    input  mem1_pkg::tlb_resp_t tlb,
    input  logic                mapped,
    input  logic                store_en,
    input  logic                interrupt,
    input  logic                overflow,
    input  logic                trap,
    output mem1_pkg::mem_exc_t  exc
);
    import mem1_pkg::*;

    logic      tlb_chk;
    logic      tlb_miss;
    logic      tlb_inv;
    logic      tlb_mod;
    logic      misal_h;
    logic      misal_w;
    logic      ades;
    logic      adel;
    exc_code_t tlb_code;

    // TLB only checked for a clean mapped load/store
    assign tlb_chk  = req.valid & (req.load | req.store) & ~req.exc_valid & mapped;
    assign tlb_miss = tlb_chk & ~tlb.found;
    assign tlb_inv  = tlb_chk & tlb.found & ~tlb.valid;
    assign tlb_mod  = tlb_chk & tlb.found & tlb.valid & ~tlb.dirty & store_en;

    // Failed SC does not write, so it counts as a load here
    assign tlb_code = tlb_mod  ? `EXC_TLBMOD :
                      store_en ? `EXC_TLBS   : `EXC_TLBL;

    assign misal_h = req.vaddr[0];
    assign misal_w = |req.vaddr[1:0];

    assign ades = req.valid & req.store &
                  ((req.dm_sel == `DM_SH & misal_h) | (req.dm_sel == `DM_SW & misal_w));
    assign adel = req.valid & req.load & req.reg_write &
                  ((req.dm_sel == `DM_LW & misal_w) |
                   ((req.dm_sel == `DM_LH | req.dm_sel == `DM_LHU) & misal_h));

    always_comb begin
        exc = '0;
        if (req.valid && interrupt) begin
            exc.exception = 1'b1;
            exc.exc_code  = `EXC_INT;
        end else if (req.valid && req.exc_valid) begin
            exc.exception  = 1'b1;
            exc.exc_code   = req.exc_code;
            exc.tlb_refill = req.exc_tlb_refill;
        end else if (req.valid && overflow) begin
            exc.exception = 1'b1;
            exc.exc_code  = `EXC_OV;
        end else if (req.valid && trap) begin
            exc.exception = 1'b1;
            exc.exc_code  = `EXC_TRAP;
        end else if (ades) begin
            exc.exception = 1'b1;
            exc.exc_code  = `EXC_ADES;
            exc.badvaddr  = req.vaddr;
        end else if (adel) begin
            exc.exception = 1'b1;
            exc.exc_code  = `EXC_ADEL;
            exc.badvaddr  = req.vaddr;
        end else if (tlb_miss || tlb_inv || tlb_mod) begin
            exc.exception  = 1'b1;
            exc.exc_code   = tlb_code;
            exc.badvaddr   = req.vaddr;
            exc.tlb_refill = tlb_miss;  // Refill vector only on a miss
        end
        exc.tlb_exc = exc.exception & (exc.exc_code == `EXC_TLBMOD |
                                       exc.exc_code == `EXC_TLBL |
                                       exc.exc_code == `EXC_TLBS);
        exc.flush = exc.exception;
    end

endmodule

/* ll_sc_monitor.sv */
`timescale 1ns/100ps

module ll_sc_monitor (
    input  logic             clk,
    input  logic             rst,
    input  logic             accept,
    input  logic             ll,
    input  logic             sc,
    input  mem1_pkg::vaddr_t vaddr,
    input  logic             flush,
    output logic             sc_ok
);
    import mem1_pkg::*;

    logic   link;
    vaddr_t link_addr;

    // Flush beats a simultaneous LL
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            link      <= 1'b0;
            link_addr <= '0;
        end else if (accept && ll) begin
            link      <= 1'b1;
            link_addr <= vaddr;
        end
    end

    assign sc_ok = sc & link & (vaddr == link_addr);

endmodule

/* access_format.sv */
`timescale 1ns/100ps

`include "mem1_stage_macros.svh"

module access_format (
    input  mem1_pkg::dm_sel_t   dm_sel,
    input  logic [1:0]          paddr_lo,
    input  mem1_pkg::word_t     store_data,
    output mem1_pkg::wstrb_t    wstrb,
    output mem1_pkg::word_t     wdata,
    output mem1_pkg::rstrb_t    rstrb,
    output mem1_pkg::acc_size_t size
);

    // Byte strobes and replicated store data
    always_comb begin
        wstrb = 4'b1111;
        wdata = store_data;
        case (dm_sel)
            `DM_SB: begin
                wstrb = 4'b0001 << paddr_lo;
                wdata = {4{store_data[7:0]}};
            end
            `DM_SH: begin
                wstrb = paddr_lo[1] ? 4'b1100 : 4'b0011;
                wdata = {2{store_data[15:0]}};
            end
            `DM_SWL: begin
                case (paddr_lo)
                    2'b00:   begin wstrb = 4'b0001; wdata = {4{store_data[31:24]}}; end
                    2'b01:   begin wstrb = 4'b0011; wdata = {2{store_data[31:16]}}; end
                    2'b10:   begin wstrb = 4'b0111; wdata = {8'b0, store_data[31:8]}; end
                    default: begin wstrb = 4'b1111; wdata = store_data; end
                endcase
            end
            `DM_SWR: begin
                case (paddr_lo)
                    2'b00:   begin wstrb = 4'b1111; wdata = store_data; end
                    2'b01:   begin wstrb = 4'b1110; wdata = {store_data[23:0], 8'b0}; end
                    2'b10:   begin wstrb = 4'b1100; wdata = {2{store_data[15:0]}}; end
                    default: begin wstrb = 4'b1000; wdata = {4{store_data[7:0]}}; end
                endcase
            end
            default: ;  // SW, SC and loads keep full word
        endcase
    end

    // Load extract code {merge, sign, half, offset}
    always_comb begin
        case (dm_sel)
            `DM_LBU: rstrb = {3'b000, paddr_lo};
            `DM_LB:  rstrb = {3'b010, paddr_lo};
            `DM_LHU: rstrb = {3'b001, paddr_lo[1], 1'b0};
            `DM_LH:  rstrb = {3'b011, paddr_lo[1], 1'b0};
            `DM_LWL: begin
                case (paddr_lo)
                    2'b00:   rstrb = 5'b11000;
                    2'b01:   rstrb = 5'b11100;
                    2'b10:   rstrb = 5'b11110;
                    default: rstrb = 5'b11111;
                endcase
            end
            `DM_LWR: begin
                case (paddr_lo)
                    2'b00:   rstrb = 5'b11111;
                    2'b01:   rstrb = 5'b10111;
                    2'b10:   rstrb = 5'b10011;
                    default: rstrb = 5'b10001;
                endcase
            end
            default: rstrb = 5'b11111;
        endcase
    end

    always_comb begin
        case (dm_sel)
            `DM_SB, `DM_LBU, `DM_LB: size = 3'd0;
            `DM_SH, `DM_LHU, `DM_LH: size = 3'd1;
            default:                 size = 3'd2;
        endcase
    end

endmodule

/* mem1_stage.sv */
`timescale 1ns/100ps

module mem1_stage (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  stall,
    input  mem1_pkg::mem_req_t    req,
    input  mem1_pkg::tlb_resp_t   tlb,
    input  logic                  interrupt,
    input  logic                  overflow,
    input  logic                  trap,
    input  logic                  cfg_we,
    input  mem1_pkg::cattr_t      cfg_k0,
    output logic                  out_valid,
    output mem1_pkg::mem_access_t acc,
    output mem1_pkg::mem_exc_t    exc
);
    import mem1_pkg::*;

    cattr_t      k0_attr;
    paddr_t      paddr;
    logic        mapped;
    logic        uncached;
    logic        accept;
    logic        sc_ok;
    logic        store_en;
    logic        go;
    logic        mem_op;
    mem_exc_t    exc_d;
    mem_access_t acc_d;

    struct packed {
        logic        valid;
        mem_access_t acc;
        mem_exc_t    exc;
    } out_d, out_q;

    assign accept   = req.valid & ~stall;
    assign store_en = req.store & (~req.sc | sc_ok);  // SC writes only with the link intact
    assign go       = req.valid & ~exc_d.exception;
    assign mem_op   = go & (req.load | store_en);

    k0_config_regs i_k0_config_regs (
        .clk     (clk),
        .rst     (rst),
        .cfg_we  (cfg_we),
        .cfg_k0  (cfg_k0),
        .k0_attr (k0_attr)
    );

    addr_xlate i_addr_xlate (
        .vaddr    (req.vaddr),
        .tlb      (tlb),
        .k0_attr  (k0_attr),
        .paddr    (paddr),
        .mapped   (mapped),
        .uncached (uncached)
    );

    ll_sc_monitor i_ll_sc_monitor (
        .clk    (clk),
        .rst    (rst),
        .accept (accept),
        .ll     (req.ll),
        .sc     (req.sc),
        .vaddr  (req.vaddr),
        .flush  (exc_d.flush & accept),
        .sc_ok  (sc_ok)
    );

    mem_exc_gen i_mem_exc_gen (
        .req       (req),
        .tlb       (tlb),
        .mapped    (mapped),
        .store_en  (store_en),
        .interrupt (interrupt),
        .overflow  (overflow),
        .trap      (trap),
        .exc       (exc_d)
    );

    access_format i_access_format (
        .dm_sel     (req.dm_sel),
        .paddr_lo   (paddr[1:0]),
        .store_data (req.wdata),
        .wstrb      (acc_d.wstrb),
        .wdata      (acc_d.wdata),
        .rstrb      (acc_d.rstrb),
        .size       (acc_d.size)
    );

    assign acc_d.paddr         = paddr;
    assign acc_d.uncached      = uncached;
    assign acc_d.dcache_valid  = mem_op & ~uncached;
    assign acc_d.uncache_valid = mem_op & uncached;
    assign acc_d.store_en      = go & store_en;
    assign acc_d.sc_result     = go & req.sc & sc_ok;

    assign out_d.valid = req.valid;
    assign out_d.acc   = acc_d;
    assign out_d.exc   = exc_d;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_q <= '0;
        end else if (!stall) begin
            out_q <= out_d;
        end
    end

    assign out_valid = out_q.valid;
    assign acc       = out_q.acc;
    assign exc       = out_q.exc;

endmodule

/* mem1_stage_checker.sv */
`timescale 1ns/100ps

module mem1_stage_checker (
    input logic                  clk,
    input logic                  rst,
    input logic                  stall,
    input logic                  out_valid,
    input mem1_pkg::mem_access_t acc,
    input mem1_pkg::mem_exc_t    exc
);
    import mem1_pkg::*;

    // Reset leaves the output register empty
    quiet_after_reset: assert property (@(posedge clk)
        rst |=> !out_valid && !acc.dcache_valid && !acc.uncache_valid &&
                !acc.store_en && !exc.exception)
        else $error("outputs active after reset");

    one_target: assert property (@(posedge clk) disable iff (rst)
        !(acc.dcache_valid && acc.uncache_valid))
        else $error("dcache and uncache requested together");

    exc_blocks_access: assert property (@(posedge clk) disable iff (rst)
        exc.exception |-> !acc.dcache_valid && !acc.uncache_valid && !acc.store_en)
        else $error("memory access alongside an exception");

    stall_holds: assert property (@(posedge clk) disable iff (rst)
        stall |=> $stable(out_valid) && $stable(acc) && $stable(exc))
        else $error("output register moved under stall");

endmodule

bind mem1_stage mem1_stage_checker i_mem1_stage_checker (
    .clk       (clk),
    .rst       (rst),
    .stall     (stall),
    .out_valid (out_valid),
    .acc       (acc),
    .exc       (exc)
);

/* tb_mem1_stage.sv */
`timescale 1ns/100ps

`include "mem1_stage_macros.svh"

module tb_mem1_stage;
    import mem1_pkg::*;

    localparam int N_RAND = 400;
    localparam int LIMIT  = 2 * (N_RAND + 16);  // Reset, directed and stall cycles

    logic        clk;
    logic        rst;
    logic        stall;
    logic        interrupt;
    logic        overflow;
    logic        trap;
    logic        cfg_we;
    cattr_t      cfg_k0;
    mem_req_t    req;
    tlb_resp_t   tlb;
    logic        out_valid;
    mem_access_t acc;
    mem_exc_t    exc;

    mem_access_t exp_acc;
    mem_exc_t    exp_exc;
    logic        m_link;    // Model of the LL link
    vaddr_t      m_addr;
    cattr_t      m_k0;
    int          cycles;

    mem1_stage i_mem1_stage (
        .clk(clk), .rst(rst), .stall(stall), .req(req), .tlb(tlb),
        .interrupt(interrupt), .overflow(overflow), .trap(trap),
        .cfg_we(cfg_we), .cfg_k0(cfg_k0),
        .out_valid(out_valid), .acc(acc), .exc(exc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > LIMIT) begin
            $display("Run did not finish within %0d cycles, stimulus hung", LIMIT);
            $display("TEST FAIL");
            $fatal(1);
        end
    end

    task automatic report_mismatch(string msg);
        $display("mismatch at %0t ns: %s", $time, msg);
        $display("TEST FAIL");
        $fatal(1);
    endtask

    // {wstrb, wdata, rstrb, size} from the access tables
    function automatic logic [43:0] format_table(dm_sel_t d, logic [1:0] a, word_t s);
        wstrb_t    w;
        word_t     x;
        rstrb_t    r;
        acc_size_t z;
        w = 4'hf;
        x = s;
        r = 5'b11111;
        z = 3'd2;
        case (d)
            `DM_SB: begin
                w = 4'b0001 << a;
                x = {4{s[7:0]}};
                z = 3'd0;
            end
            `DM_SH: begin
                w = a[1] ? 4'b1100 : 4'b0011;
                x = {2{s[15:0]}};
                z = 3'd1;
            end
            `DM_SWL: begin
                case (a)
                    2'd0: begin
                        w = 4'b0001;
                        x = {4{s[31:24]}};
                    end
                    2'd1: begin
                        w = 4'b0011;
                        x = {2{s[31:16]}};
                    end
                    2'd2: begin
                        w = 4'b0111;
                        x = {8'h0, s[31:8]};
                    end
                    default: ;
                endcase
            end
            `DM_SWR: begin
                case (a)
                    2'd1: begin
                        w = 4'b1110;
                        x = {s[23:0], 8'h0};
                    end
                    2'd2: begin
                        w = 4'b1100;
                        x = {2{s[15:0]}};
                    end
                    2'd3: begin
                        w = 4'b1000;
                        x = {4{s[7:0]}};
                    end
                    default: ;
                endcase
            end
            `DM_LBU: begin
                r = {3'b000, a};
                z = 3'd0;
            end
            `DM_LB: begin
                r = {3'b010, a};
                z = 3'd0;
            end
            `DM_LHU: begin
                r = {3'b001, a[1], 1'b0};
                z = 3'd1;
            end
            `DM_LH: begin
                r = {3'b011, a[1], 1'b0};
                z = 3'd1;
            end
            `DM_LWL: r = {2'b11, 3'(3'b111 << (2'd3 - a))};
            `DM_LWR: r = {1'b1, 4'b1111 >> a};
            default: ;
        endcase
        return {w, x, r, z};
    endfunction

    // Expected outputs of the current request, and link update on acceptance
    task automatic predict();
        logic mapped;
        logic unc;
        logic sc_ok;
        logic st;
        logic chk;
        logic md;
        logic misal;
        exp_acc = '0;
        exp_exc = '0;
        mapped  = !req.vaddr[31] || req.vaddr[30];
        exp_acc.paddr = mapped ? {tlb.pfn, req.vaddr[11:0]} : {3'b000, req.vaddr[28:0]};
        unc   = !((req.vaddr[31:29] == 3'b100 && m_k0 == 3'd3) || (mapped && tlb.cattr == 3'd3));
        sc_ok = req.sc && m_link && req.vaddr == m_addr;
        st    = req.store && (!req.sc || sc_ok);
        chk   = (req.load || req.store) && !req.exc_valid && mapped;
        md    = tlb.found && tlb.valid && !tlb.dirty && st;
        misal = (req.dm_sel == `DM_SW || req.dm_sel == `DM_LW) ? |req.vaddr[1:0] : req.vaddr[0];
        exp_exc.exception = 1'b1;
        if (interrupt) begin
            exp_exc.exc_code = `EXC_INT;
        end else if (req.exc_valid) begin
            exp_exc.exc_code   = req.exc_code;
            exp_exc.tlb_refill = req.exc_tlb_refill;
        end else if (overflow) begin
            exp_exc.exc_code = `EXC_OV;
        end else if (trap) begin
            exp_exc.exc_code = `EXC_TRAP;
        end else if (req.store && misal && (req.dm_sel == `DM_SH || req.dm_sel == `DM_SW)) begin
            exp_exc.exc_code = `EXC_ADES;
            exp_exc.badvaddr = req.vaddr;
        end else if (req.load && req.reg_write && misal && (req.dm_sel == `DM_LW ||
                     req.dm_sel == `DM_LH || req.dm_sel == `DM_LHU)) begin
            exp_exc.exc_code = `EXC_ADEL;
            exp_exc.badvaddr = req.vaddr;
        end else if (chk && (!tlb.found || !tlb.valid || md)) begin
            exp_exc.exc_code   = md ? `EXC_TLBMOD : (st ? `EXC_TLBS : `EXC_TLBL);
            exp_exc.badvaddr   = req.vaddr;
            exp_exc.tlb_refill = !tlb.found;
        end else begin
            exp_exc.exception = 1'b0;
        end
        exp_exc.tlb_exc = exp_exc.exception && exp_exc.exc_code inside {5'd1, 5'd2, 5'd3};
        exp_exc.flush   = exp_exc.exception;
        exp_acc.uncached      = unc;
        exp_acc.dcache_valid  = !exp_exc.exception && (req.load || st) && !unc;
        exp_acc.uncache_valid = !exp_exc.exception && (req.load || st) && unc;
        exp_acc.store_en      = !exp_exc.exception && st;
        exp_acc.sc_result     = !exp_exc.exception && sc_ok;
        {exp_acc.wstrb, exp_acc.wdata, exp_acc.rstrb, exp_acc.size} =
            format_table(req.dm_sel, exp_acc.paddr[1:0], req.wdata);
        if (exp_exc.exception) begin
            m_link = 1'b0;
        end else if (req.ll) begin
            m_link = 1'b1;
            m_addr = req.vaddr;
        end
    endtask

    // One accepted request, checked one cycle later at the falling edge
    task automatic step(string tag);
        predict();
        @(posedge clk);
        if (cfg_we) m_k0 = cfg_k0;
        @(negedge clk);
        cfg_we = 1'b0;
        assert (out_valid === 1'b1) else report_mismatch({tag, " out_valid low"});
        assert (acc === exp_acc)
            else report_mismatch($sformatf("%s acc %h exp %h", tag, acc, exp_acc));
        assert (exc === exp_exc)
            else report_mismatch($sformatf("%s exc %h exp %h", tag, exc, exp_exc));
    endtask

    task automatic set_req(dm_sel_t d, vaddr_t va, logic ll, logic sc);
        req = '0;
        req.valid     = 1'b1;
        req.vaddr     = va;
        req.wdata     = $urandom;
        req.dm_sel    = d;
        req.load      = d >= `DM_LBU;
        req.store     = d < `DM_LBU;
        req.reg_write = d >= `DM_LBU;
        req.ll        = ll;
        req.sc        = sc;
        interrupt = 1'b0;
        overflow  = 1'b0;
        trap      = 1'b0;
        tlb = {1'b1, 1'b1, 1'b1, 20'($urandom), 3'd3};
    endtask

    task automatic random_req();
        vaddr_t va;
        va = $urandom;
        if ($urandom_range(3, 0) == 0) va[31:30] = 2'b10;   // More unmapped hits
        set_req(4'($urandom_range(11, 0)), va, 1'b0, 1'b0);
        if ($urandom_range(7, 0) == 0) begin
            req.ll = req.load;
            req.sc = req.store;
        end
        interrupt = $urandom_range(15, 0) == 0;
        overflow  = $urandom_range(15, 0) == 0;
        trap      = $urandom_range(15, 0) == 0;
        req.exc_valid      = $urandom_range(15, 0) == 0;
        req.exc_code       = 5'($urandom);
        req.exc_tlb_refill = 1'($urandom);
        tlb = {$urandom_range(7, 0) != 0, $urandom_range(7, 0) != 0, 1'($urandom),
               20'($urandom), 3'($urandom)};
        if ($urandom_range(15, 0) == 0) begin
            cfg_we = 1'b1;
            cfg_k0 = 3'($urandom);
        end
    endtask

    initial begin
        mem_access_t held_acc;
        mem_exc_t    held_exc;
        void'($urandom(19));
        rst = 1'b1;
        stall = 1'b0;
        cfg_we = 1'b0;
        cfg_k0 = '0;
        cycles = 0;
        m_link = 1'b0;
        m_addr = '0;
        m_k0   = `K0_RESET_ATTR;
        set_req(`DM_LW, '0, 1'b0, 1'b0);
        req.valid = 1'b0;
        repeat (3) @(negedge clk);
        rst = 1'b0;
        assert (!out_valid && !acc.dcache_valid && !acc.uncache_valid && !acc.store_en &&
                !exc.exception) else report_mismatch("outputs not quiet after reset");

        set_req(`DM_LW, 32'h8000_1000, 1'b0, 1'b0);
        step("kseg0 cached");
        set_req(`DM_SW, 32'ha000_2004, 1'b0, 1'b0);
        cfg_we = 1'b1;
        cfg_k0 = `CATTR_UNCACHED;
        step("kseg1");
        set_req(`DM_LW, 32'h8000_3000, 1'b0, 1'b0);
        step("kseg0 after write");

        set_req(`DM_LW, 32'h0000_4000, 1'b1, 1'b0);
        step("ll");
        set_req(`DM_SW, 32'h0000_4000, 1'b0, 1'b1);
        step("sc same");
        set_req(`DM_SW, 32'h0000_4008, 1'b0, 1'b1);
        step("sc other");
        set_req(`DM_LW, 32'h0000_5000, 1'b1, 1'b0);
        step("ll again");
        set_req(`DM_LW, 32'h0000_6000, 1'b0, 1'b0);
        interrupt = 1'b1;
        step("interrupt");
        set_req(`DM_SW, 32'h0000_5000, 1'b0, 1'b1);
        step("sc after exception");

        repeat (N_RAND) begin
            random_req();
            step("random");
        end

        held_acc = acc;
        held_exc = exc;
        random_req();
        cfg_we = 1'b0;
        stall = 1'b1;
        repeat (3) @(negedge clk);
        assert (acc === held_acc && exc === held_exc && out_valid === 1'b1)
            else report_mismatch("outputs changed during stall");
        stall = 1'b0;
        step("after stall");

        $display("TEST PASS");
        $finish;
    end

endmodule

/* mem1_stage.f */
+incdir+.
mem1_pkg.sv
k0_config_regs.sv
addr_xlate.sv
mem_exc_gen.sv
ll_sc_monitor.sv
access_format.sv
mem1_stage.sv
mem1_stage_checker.sv
tb_mem1_stage.sv

/* run.sh */
#!/bin/sh
set -e

verilator --binary --timing --assert --top-module tb_mem1_stage \
    -f mem1_stage.f -o sim_mem1_stage

./obj_dir/sim_mem1_stage > sim.log 2>&1
cat sim.log

if grep -q "TEST FAIL" sim.log; then
    exit 1
fi
exit 0
